// File: dv/mipsCpuTests.svh
`ifndef MIPS_CPU_TESTS_SVH
`define MIPS_CPU_TESTS_SVH

  // MIPS-I primary opcodes
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opBne   = 6'h05;
  localparam logic [5:0] opAddiu = 6'h09;
  localparam logic [5:0] opSlti  = 6'h0a;
  localparam logic [5:0] opAndi  = 6'h0c;
  localparam logic [5:0] opOri   = 6'h0d;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;
  localparam logic [5:0] fnAddu  = 6'h21;   // R-type funct codes
  localparam logic [5:0] fnAnd   = 6'h24;
  localparam logic [5:0] fnOr    = 6'h25;

  function automatic word_t rType(input logic [5:0] funct, input int rd, input int rs,
                                  input int rt);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic word_t iType(input logic [5:0] op, input int rt, input int rs,
                                  input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic word_t jType(input word_t target);
    return {opJ, target[27:2]};
  endfunction

  function automatic word_t sext(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  function automatic word_t zext(input logic [15:0] imm);
    return {16'h0000, imm};
  endfunction

  function automatic word_t fillPattern(input word_t byteAddr);
    return {20'hdead0, byteAddr[11:0]};
  endfunction

  // Fill memory and point the loader at the reset vector
  task automatic clearMemory();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = fillPattern(i * 4);
    end
    progPtr = 32'h100;
  endtask

  task automatic emit(input word_t instrWord);
    mem[progPtr[11:2]] = instrWord;
    progPtr += 4;
  endtask

  task automatic preload(input word_t byteAddr, input word_t value);
    mem[byteAddr[11:2]] = value;
  endtask

  task automatic resetState();
    int cycles;
    clearMemory();
    emit(iType(opAddiu, 1, 0, 16'h0011));
    emit(iType(opSw, 1, 0, 16'h0500));
    emit(jType(32'h0));
    @(posedge clk);
    rstN <= 1'b0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (i == 4) begin
        rstN <= 1'b1;
      end
      @(negedge clk);
      checkCount++;
      if (memReq.read || memReq.write) begin
        $display("resetState: a bus strobe was high during reset");
        errorCount++;
      end
    end
    checkCount++;
    if (!active) begin
      $display("resetState: active was low after reset release");
      errorCount++;
    end
    cycles = 0;
    while (!memReq.read && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    checkCount++;
    if (!memReq.read) begin
      $display("resetState: no instruction fetch started after reset");
      errorCount++;
    end else if (memReq.address !== 32'h100) begin
      $display("[FAIL] resetState: first read address expected %h, actual %h",
               32'h100, memReq.address);
      errorCount++;
    end
    waitHalt("resetState");
    checkWord("resetState", 32'h500, sext(16'h0011));
  endtask

  task automatic aluOps();
    word_t r [10];
    clearMemory();
    emit(iType(opAddiu, 1, 0, 16'h1234));
    emit(iType(opAddiu, 2, 0, 16'hfffb));   // -5
    emit(iType(opOri, 3, 0, 16'h8001));
    emit(iType(opAndi, 4, 2, 16'hf0f0));
    emit(rType(fnAddu, 5, 1, 2));
    emit(rType(fnAnd, 6, 2, 1));
    emit(rType(fnOr, 7, 1, 3));
    emit(iType(opSlti, 8, 2, 16'h0001));
    emit(iType(opSlti, 9, 1, 16'hffff));
    for (int k = 1; k < 10; k++) begin
      emit(iType(opSw, k, 0, 16'h0600 + {k[13:0], 2'b00}));
    end
    emit(jType(32'h0));
    runProgram("aluOps");
    r[1] = sext(16'h1234);
    r[2] = sext(16'hfffb);
    r[3] = zext(16'h8001);
    r[4] = r[2] & zext(16'hf0f0);
    r[5] = r[1] + r[2];
    r[6] = r[2] & r[1];
    r[7] = r[1] | r[3];
    r[8] = ($signed(r[2]) < $signed(sext(16'h0001))) ? 32'd1 : 32'd0;
    r[9] = ($signed(r[1]) < $signed(sext(16'hffff))) ? 32'd1 : 32'd0;
    for (int k = 1; k < 10; k++) begin
      checkWord("aluOps", 32'h600 + k * 4, r[k]);
    end
  endtask

  task automatic loadStore();
    clearMemory();
    preload(32'h300, 32'h89ab_cdef);
    preload(32'h308, 32'h1357_9bdf);
    emit(iType(opLw, 2, 0, 16'h0300));
    emit(iType(opSw, 2, 0, 16'h0304));
    emit(iType(opAddiu, 3, 0, 16'h0300));
    emit(iType(opLw, 4, 3, 16'h0008));
    emit(iType(opSw, 4, 3, 16'hfffc));      // Negative offset to 0x2fc
    emit(iType(opAddiu, 0, 0, 16'h0055));   // Lost write to $zero
    emit(iType(opSw, 0, 0, 16'h030c));
    emit(rType(fnAddu, 5, 2, 4));
    emit(iType(opSw, 5, 0, 16'h0310));
    emit(iType(opAddiu, 6, 0, 16'h8765));
    emit(iType(opSw, 6, 0, 16'h0314));
    emit(iType(opLw, 7, 0, 16'h0314));      // Read back what was stored
    emit(iType(opSw, 7, 0, 16'h0318));
    emit(jType(32'h0));
    runProgram("loadStore");
    checkWord("loadStore", 32'h300, 32'h89ab_cdef);
    checkWord("loadStore", 32'h304, 32'h89ab_cdef);
    checkWord("loadStore", 32'h2fc, 32'h1357_9bdf);
    checkWord("loadStore", 32'h30c, 32'h0);
    checkWord("loadStore", 32'h310, 32'h89ab_cdef + 32'h1357_9bdf);
    checkWord("loadStore", 32'h318, sext(16'h8765));
  endtask

  // Every branch skips exactly one store when taken
  task automatic branchAndJump();
    clearMemory();
    emit(iType(opAddiu, 1, 0, 16'd7));
    emit(iType(opAddiu, 2, 0, 16'd7));
    emit(iType(opAddiu, 3, 0, 16'd9));
    emit(iType(opAddiu, 10, 0, 16'd1));     // Marker value
    emit(iType(opBeq, 2, 1, 16'd1));        // Taken
    emit(iType(opSw, 10, 0, 16'h0400));
    emit(iType(opSw, 10, 0, 16'h0404));
    emit(iType(opBeq, 3, 1, 16'd1));        // Not taken
    emit(iType(opSw, 10, 0, 16'h0408));
    emit(iType(opBne, 3, 1, 16'd1));        // Taken
    emit(iType(opSw, 10, 0, 16'h040c));
    emit(iType(opBne, 2, 1, 16'd1));        // Not taken
    emit(iType(opSw, 10, 0, 16'h0410));
    emit(jType(progPtr + 8));
    emit(iType(opSw, 10, 0, 16'h0414));
    emit(iType(opSw, 10, 0, 16'h0418));
    emit(jType(32'h0));
    runProgram("branchAndJump");
    checkWord("branchAndJump", 32'h400, fillPattern(32'h400));
    checkWord("branchAndJump", 32'h404, sext(16'd1));
    checkWord("branchAndJump", 32'h408, sext(16'd1));
    checkWord("branchAndJump", 32'h40c, fillPattern(32'h40c));
    checkWord("branchAndJump", 32'h410, sext(16'd1));
    checkWord("branchAndJump", 32'h414, fillPattern(32'h414));
    checkWord("branchAndJump", 32'h418, sext(16'd1));
  endtask

  task automatic haltQuiet();
    logic quiet;
    clearMemory();
    emit(iType(opAddiu, 1, 0, 16'h0042));
    emit(iType(opSw, 1, 0, 16'h0700));
    emit(jType(32'h0));
    runProgram("haltQuiet");
    checkWord("haltQuiet", 32'h700, sext(16'h0042));
    quiet = 1'b1;
    repeat (50) begin
      @(negedge clk);
      if (memReq.read || memReq.write || active) begin
        quiet = 1'b0;
      end
    end
    checkCount++;
    if (!quiet) begin
      $display("haltQuiet: the CPU used the bus or became active after halting");
      errorCount++;
    end
  endtask

`endif

// File: dv/mipsCpuTb.sv
`timescale 1ns/1ps

module mipsCpuTb import mipsPkg::*; ();

  logic        clk = 1'b0;
  logic        rstN = 1'b0;
  logic        waitRequest = 1'b0;
  word_t       readData;
  memReq_t     memReq;
  logic        active;

  word_t       mem [1024];   // Byte address bits [11:2]
  word_t       progPtr;      // Next free program address
  int          errorCount = 0;
  int          checkCount = 0;

  always #10 clk = ~clk;

  mipsCpu #(.resetVector(32'h100)) u_mipsCpu (
    .clk         (clk),
    .rstN        (rstN),
    .memReq      (memReq),
    .readData    (readData),
    .waitRequest (waitRequest),
    .active      (active)
  );

  // Asynchronous read port that is valid in the cycle the transfer completes
  assign readData = mem[memReq.address[11:2]];

  // Back-pressure one cycle in four
  initial begin
    void'($urandom(32'h55b9014d));
    forever begin
      @(posedge clk);
      waitRequest <= ($urandom % 4) == 0;
    end
  end

  always @(posedge clk) begin
    if (memReq.write && !waitRequest) begin
      mem[memReq.address[11:2]] <= memReq.writeData;
    end
  end

  task automatic checkWord(input string testName, input word_t byteAddr, input word_t expected);
    word_t actual;
    actual = mem[byteAddr[11:2]];
    checkCount++;
    if (actual !== expected) begin
      $display("[FAIL] %s: word at %h expected %h, actual %h",
               testName, byteAddr, expected, actual);
      errorCount++;
    end
  endtask

  task automatic pulseReset();
    @(posedge clk);
    rstN <= 1'b0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
  endtask

  // Run until active falls or 2000 cycles pass
  task automatic waitHalt(input string testName);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (active && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    checkCount++;
    if (active) begin
      $display("%s: the CPU did not halt within 2000 cycles", testName);
      errorCount++;
    end
  endtask

  task automatic runProgram(input string testName);
    pulseReset();
    waitHalt(testName);
  endtask

  `include "mipsCpuTests.svh"

  initial begin
    resetState();
    aluOps();
    loadStore();
    branchAndJump();
    haltQuiet();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: logic/mipsAlu.sv
`timescale 1ns/1ps

module mipsAlu import mipsPkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t aluOp,
  output word_t  result,
  output logic   zero
);

  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluOp)
      ALU_ADD: result = a + b;   // No overflow trap, ADDU/ADDIU semantics
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLT: result = {{(dataWidth-1){1'b0}}, lessThan};
      default: result = '0;
    endcase
  end

  // Branch compare runs a subtract and looks here
  assign zero = (result == '0);

endmodule

// File: logic/mipsControl.sv
`timescale 1ns/1ps

module mipsControl import mipsPkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  instrWord_t   instr,
  input  logic         aluZero,
  input  logic         pcIsZero,
  input  logic         waitRequest,
  output ctrlSignals_t ctrl,
  output logic         read,
  output logic         write,
  output logic         active
);

  cpuState_t state;
  cpuState_t stateNext;
  logic      running;     // Low in the first cycle after reset
  logic      fetchGo;
  opcode_t   opcode;
  funct_t    funct;
  aluOp_t    execOp;
  aluSrcB_t  execSrcB;
  logic      writesReg;
  logic      isLoad;
  logic      isStore;
  logic      isBranch;
  logic      isJump;

  assign opcode  = instr.iFields.opcode;
  assign funct   = instr.rFields.funct;
  assign fetchGo = running && !pcIsZero;

  // Instruction class and execute-stage ALU setup
  always_comb begin
    execOp    = ALU_ADD;
    execSrcB  = SRCB_IMM_SEXT;
    writesReg = 1'b0;
    isLoad    = 1'b0;
    isStore   = 1'b0;
    isBranch  = 1'b0;
    isJump    = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        execSrcB  = SRCB_REG;
        writesReg = 1'b1;
        case (funct)
          FN_ADDU: execOp = ALU_ADD;
          FN_AND:  execOp = ALU_AND;
          FN_OR:   execOp = ALU_OR;
          default: writesReg = 1'b0;   // Unknown funct acts as a no-op
        endcase
      end
      OP_ADDIU: writesReg = 1'b1;
      OP_SLTI: begin
        execOp    = ALU_SLT;
        writesReg = 1'b1;
      end
      OP_ANDI: begin
        execOp    = ALU_AND;
        execSrcB  = SRCB_IMM_ZEXT;
        writesReg = 1'b1;
      end
      OP_ORI: begin
        execOp    = ALU_OR;
        execSrcB  = SRCB_IMM_ZEXT;
        writesReg = 1'b1;
      end
      OP_LW: isLoad = 1'b1;
      OP_SW: isStore = 1'b1;
      OP_BEQ, OP_BNE: begin
        execOp   = ALU_SUB;
        execSrcB = SRCB_REG;
        isBranch = 1'b1;
      end
      OP_J: isJump = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    stateNext = state;
    case (state)
      FETCH: begin
        if (pcIsZero) begin
          stateNext = HALTED;
        end else if (running && !waitRequest) begin
          stateNext = DECODE;
        end
      end
      DECODE: stateNext = EXEC1;
      EXEC1: stateNext = (writesReg || isLoad || isStore) ? EXEC2 : FETCH;
      EXEC2: begin
        if (!(isLoad || isStore)) begin
          stateNext = FETCH;
        end else if (!waitRequest) begin
          stateNext = isLoad ? EXEC3 : FETCH;
        end
      end
      EXEC3: stateNext = FETCH;
      HALTED: stateNext = HALTED;   // Left only through reset
      default: stateNext = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= FETCH;
      running <= 1'b0;
    end else begin
      state   <= stateNext;
      running <= 1'b1;
    end
  end

  always_comb begin
    ctrl = '0;
    case (state)
      FETCH: begin
        ctrl.aluSrcB = SRCB_FOUR;                  // PC+4
        ctrl.irWrite = fetchGo;
        ctrl.pcWrite = fetchGo && !waitRequest;
      end
      DECODE: ctrl.aluSrcB = SRCB_BR_OFFSET;     // Branch target into ALUOut
      EXEC1: begin
        ctrl.aluSrcA  = 1'b1;
        ctrl.aluSrcB  = execSrcB;
        ctrl.aluOp    = execOp;
        ctrl.pcBranch = isBranch && (aluZero ^ (opcode == OP_BNE));
        ctrl.pcWrite  = isJump;
        ctrl.pcJump   = isJump;
      end
      EXEC2: begin
        ctrl.iorD     = isLoad || isStore;
        ctrl.regWrite = writesReg;
        ctrl.regDst   = (opcode == OP_RTYPE);
      end
      EXEC3: begin
        ctrl.regWrite = isLoad;
        ctrl.memToReg = 1'b1;
      end
      default: ;
    endcase
  end

  assign read   = (state == FETCH && fetchGo) || (state == EXEC2 && isLoad);
  assign write  = (state == EXEC2) && isStore;
  assign active = (state != HALTED);

  strobesExclusive: assert property (@(posedge clk) disable iff (!rstN) !(read && write));

  haltedQuiet: assert property (@(posedge clk) disable iff (!rstN)
    state == HALTED |-> !read && !write);

  // A stalled read stays up until the bus takes it
  readHeld: assert property (@(posedge clk) disable iff (!rstN)
    read && waitRequest |=> read);

endmodule

// File: logic/mipsCpu.sv
`timescale 1ns/1ps

module mipsCpu import mipsPkg::*; #(
  parameter word_t resetVector = 32'h0000_0000
) (
  input  logic    clk,
  input  logic    rstN,
  output memReq_t memReq,
  input  word_t   readData,
  input  logic    waitRequest,
  output logic    active
);

  ctrlSignals_t ctrl;
  instrWord_t   instr;
  logic         aluZero;
  logic         pcIsZero;
  logic         read;
  logic         write;
  word_t        address;
  word_t        writeData;
  word_t        aluA;
  word_t        aluB;
  word_t        aluResult;
  word_t        rdataA;
  word_t        rdataB;
  word_t        wdata;
  regAddr_t     raddrA;
  regAddr_t     raddrB;
  regAddr_t     waddr;

  assign memReq = '{address: address, read: read, write: write, writeData: writeData};

  mipsControl u_mipsControl (
    .clk         (clk),
    .rstN        (rstN),
    .instr       (instr),
    .aluZero     (aluZero),
    .pcIsZero    (pcIsZero),
    .waitRequest (waitRequest),
    .ctrl        (ctrl),
    .read        (read),
    .write       (write),
    .active      (active)
  );

  mipsDatapath #(.resetVector(resetVector)) u_mipsDatapath (
    .clk         (clk),
    .rstN        (rstN),
    .ctrl        (ctrl),
    .readData    (readData),
    .waitRequest (waitRequest),
    .aluResult   (aluResult),
    .rdataA      (rdataA),
    .rdataB      (rdataB),
    .instr       (instr),
    .pcIsZero    (pcIsZero),
    .address     (address),
    .writeData   (writeData),
    .aluA        (aluA),
    .aluB        (aluB),
    .raddrA      (raddrA),
    .raddrB      (raddrB),
    .waddr       (waddr),
    .wdata       (wdata)
  );

  mipsAlu u_mipsAlu (
    .a      (aluA),
    .b      (aluB),
    .aluOp  (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  mipsRegFile u_mipsRegFile (
    .clk    (clk),
    .raddrA (raddrA),
    .raddrB (raddrB),
    .waddr  (waddr),
    .wdata  (wdata),
    .wen    (ctrl.regWrite),
    .rdataA (rdataA),
    .rdataB (rdataB)
  );

endmodule

// File: logic/mipsDatapath.sv
`timescale 1ns/1ps

module mipsDatapath import mipsPkg::*; #(
  parameter word_t resetVector = 32'h0000_0000
) (
  input  logic         clk,
  input  logic         rstN,
  input  ctrlSignals_t ctrl,
  input  word_t        readData,
  input  logic         waitRequest,
  input  word_t        aluResult,
  input  word_t        rdataA,
  input  word_t        rdataB,
  output instrWord_t   instr,
  output logic         pcIsZero,
  output word_t        address,
  output word_t        writeData,
  output word_t        aluA,
  output word_t        aluB,
  output regAddr_t     raddrA,
  output regAddr_t     raddrB,
  output regAddr_t     waddr,
  output word_t        wdata
);

  word_t      pc;
  instrWord_t ir;
  word_t      regA;
  word_t      regB;
  word_t      aluOut;
  word_t      mdr;
  word_t      nextPc;
  word_t      jumpTarget;
  word_t      immSext;
  word_t      immZext;
  logic       busDone;

  assign busDone = !waitRequest;   // Transfer completes this cycle

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetVector;
    end else if (ctrl.pcWrite || ctrl.pcBranch) begin
      pc <= nextPc;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite && busDone) begin
      ir <= readData;
    end
    if (ctrl.iorD && busDone) begin
      mdr <= readData;
    end
    // ALUOut is the bus address during a data access, so it holds there
    if (!ctrl.iorD) begin
      aluOut <= aluResult;
    end
    regA <= rdataA;
    regB <= rdataB;
  end

  assign immSext    = {{16{ir.iFields.imm16[15]}}, ir.iFields.imm16};
  assign immZext    = {16'h0000, ir.iFields.imm16};
  assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};   // PC already at PC+4

  always_comb begin
    if (ctrl.pcJump) begin
      nextPc = jumpTarget;
    end else if (ctrl.pcBranch) begin
      nextPc = aluOut;      // Target from DECODE
    end else begin
      nextPc = aluResult;   // PC+4 in FETCH
    end
  end

  assign aluA = ctrl.aluSrcA ? regA : pc;

  always_comb begin
    case (ctrl.aluSrcB)
      SRCB_REG:       aluB = regB;
      SRCB_FOUR:      aluB = 32'd4;
      SRCB_IMM_SEXT:  aluB = immSext;
      SRCB_IMM_ZEXT:  aluB = immZext;
      SRCB_BR_OFFSET: aluB = {immSext[29:0], 2'b00};
      default:        aluB = '0;
    endcase
  end

  assign raddrA = ir.rFields.rs;
  assign raddrB = ir.rFields.rt;
  assign waddr  = ctrl.regDst ? ir.rFields.rd : ir.rFields.rt;
  assign wdata  = ctrl.memToReg ? mdr : aluOut;

  assign instr     = ir;
  assign pcIsZero  = (pc == '0);
  assign address   = ctrl.iorD ? aluOut : pc;
  assign writeData = regB;

endmodule

// File: logic/mipsPkg.sv
package mipsPkg;

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;

  typedef logic [dataWidth-1:0]    word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // Primary opcodes, MIPS encoding
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_BEQ   = 6'b000100,
    OP_BNE   = 6'b000101,
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_t;

  typedef enum logic [5:0] {
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT   // Signed compare
  } aluOp_t;

  typedef enum logic [2:0] {
    SRCB_REG,
    SRCB_FOUR,
    SRCB_IMM_SEXT,
    SRCB_IMM_ZEXT,
    SRCB_BR_OFFSET   // Sign-extended immediate times 4
  } aluSrcB_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC1,
    EXEC2,
    EXEC3,
    HALTED
  } cpuState_t;

  typedef struct packed {
    opcode_t    opcode;
    regAddr_t   rs;
    regAddr_t   rt;
    regAddr_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } rFields_t;

  typedef struct packed {
    opcode_t     opcode;
    regAddr_t    rs;
    regAddr_t    rt;
    logic [15:0] imm16;
  } iFields_t;

  // One instruction word, R and I views; J target is the low 26 bits
  typedef union packed {
    rFields_t rFields;
    iFields_t iFields;
  } instrWord_t;

  typedef struct packed {
    logic     pcWrite;
    logic     pcBranch;   // Taken branch, PC loads ALUOut
    logic     pcJump;
    logic     irWrite;
    logic     iorD;       // Bus address from ALUOut instead of PC
    logic     aluSrcA;
    aluSrcB_t aluSrcB;
    aluOp_t   aluOp;
    logic     regWrite;
    logic     regDst;     // rd when set, rt otherwise
    logic     memToReg;
  } ctrlSignals_t;

  typedef struct packed {
    word_t address;
    logic  read;
    logic  write;
    word_t writeData;
  } memReq_t;

endpackage

// File: logic/mipsRegFile.sv
`timescale 1ns/1ps

module mipsRegFile import mipsPkg::*; (
  input  logic     clk,
  input  regAddr_t raddrA,
  input  regAddr_t raddrB,
  input  regAddr_t waddr,
  input  word_t    wdata,
  input  logic     wen,
  output word_t    rdataA,
  output word_t    rdataB
);

  word_t regs [2**regAddrWidth];

  // Writes to $zero are dropped
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Asynchronous reads, entry 0 masked to zero
  assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

  zeroReg: assert property (@(posedge clk)
    (raddrA == '0 |-> rdataA == '0) and (raddrB == '0 |-> rdataB == '0));

endmodule

// File: sim.f
logic/mipsPkg.sv
logic/mipsAlu.sv
logic/mipsRegFile.sv
logic/mipsControl.sv
logic/mipsDatapath.sv
logic/mipsCpu.sv
+incdir+dv
dv/mipsCpuTb.sv
